//--- hdl/usart_reg_pkg.sv
package usart_reg_pkg;

	typedef logic [11:0] reg_addr_t;
	typedef logic [11:0] baud_t;

	// Default register map
	localparam reg_addr_t UCSRA_ADDR_DEF = 12'h0C0;
	localparam reg_addr_t UCSRB_ADDR_DEF = 12'h0C1;
	localparam reg_addr_t UCSRC_ADDR_DEF = 12'h0C2;
	localparam reg_addr_t UBRRL_ADDR_DEF = 12'h0C4;
	localparam reg_addr_t UBRRH_ADDR_DEF = 12'h0C5;
	localparam reg_addr_t UDR_ADDR_DEF   = 12'h0C6;

	// UCSRA
	localparam int RXC  = 7;
	localparam int TXC  = 6;
	localparam int UDRE = 5;
	localparam int FE   = 4;
	localparam int DOR  = 3;
	localparam int UPE  = 2;
	localparam int U2X  = 1;

	// UCSRB
	localparam int RXCIE = 7;
	localparam int TXCIE = 6;
	localparam int UDRIE = 5;
	localparam int RXEN  = 4;
	localparam int TXEN  = 3;
	localparam int UCSZ2 = 2;
	localparam int RXB8  = 1;
	localparam int TXB8  = 0;

	// UCSRC
	localparam int UPM1  = 5;
	localparam int UPM0  = 4;
	localparam int USBS  = 3;
	localparam int UCSZ1 = 2;
	localparam int UCSZ0 = 1;

	localparam logic [7:0] UCSRC_RST = 8'h06; // 8 data bits, no parity, 1 stop

endpackage

//--- hdl/usart_frame_pkg.sv
package usart_frame_pkg;

	// UCSZ2 and UCSZ1:0 concatenated
	typedef enum logic [2:0] {
		CS_5 = 3'b000,
		CS_6 = 3'b001,
		CS_7 = 3'b010,
		CS_8 = 3'b011,
		CS_9 = 3'b111
	} char_size_e;

	localparam int MAX_DATA_W     = 9;
	localparam int TX_FRAME_W     = 10; // Start bit not included
	localparam int OVERSAMPLE     = 16;
	localparam int OVERSAMPLE_U2X = 8;

	typedef logic [TX_FRAME_W-1:0] tx_frame_t;

	typedef struct packed {
		logic                  fe;
		logic                  pe;
		logic [MAX_DATA_W-1:0] data; // Right-aligned
	} rx_entry_t;

	// Reserved codes behave as 8 bits
	function automatic char_size_e to_char_size(input logic [2:0] ucsz);
		case (ucsz)
			3'b000:  return CS_5;
			3'b001:  return CS_6;
			3'b010:  return CS_7;
			3'b111:  return CS_9;
			default: return CS_8;
		endcase
	endfunction

	function automatic logic [3:0] char_bits(input char_size_e cs);
		case (cs)
			CS_5:    return 4'd5;
			CS_6:    return 4'd6;
			CS_7:    return 4'd7;
			CS_9:    return 4'd9;
			default: return 4'd8;
		endcase
	endfunction

endpackage

//--- hdl/usart_frame_if.sv
`timescale 1ns/1ns

interface usart_frame_if;
	import usart_frame_pkg::*;

	char_size_e char_size;
	logic       parity_en;
	logic       parity_odd;
	logic       two_stop;     // Transmit only
	logic       double_speed;

	modport ctrl_mp (
		output char_size, parity_en, parity_odd, two_stop, double_speed
	);

	modport tx_mp (
		input char_size, parity_en, parity_odd, two_stop, double_speed
	);

	modport rx_mp (
		input char_size, parity_en, parity_odd, two_stop, double_speed
	);

endinterface

//--- hdl/usart_ctrl.sv
`timescale 1ns/1ns

module usart_ctrl #(
	parameter usart_reg_pkg::reg_addr_t UDR_ADDR   = usart_reg_pkg::UDR_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRA_ADDR = usart_reg_pkg::UCSRA_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRB_ADDR = usart_reg_pkg::UCSRB_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRC_ADDR = usart_reg_pkg::UCSRC_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UBRRH_ADDR = usart_reg_pkg::UBRRH_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UBRRL_ADDR = usart_reg_pkg::UBRRL_ADDR_DEF
) (
	input  logic                       cp2,
	input  logic                       ireset,
	input  usart_reg_pkg::reg_addr_t   ram_addr_i,
	input  logic                       ramre_i,
	input  logic                       ramwe_i,
	input  logic [7:0]                 dbus_i,
	output logic [7:0]                 dbus_o,
	output logic                       out_en_o,
	output logic                       rxc_irq_o,
	output logic                       txc_irq_o,
	output logic                       udre_irq_o,
	usart_frame_if.ctrl_mp             frame,
	output usart_reg_pkg::baud_t       baud_o,
	output logic                       baud_load_o,
	output logic                       rxen_o,
	output logic                       txen_o,
	output logic                       tx_wr_o,
	output usart_frame_pkg::tx_frame_t tx_frame_o,
	input  logic                       tx_full_i,
	input  logic                       tx_done_i,
	output logic                       rx_pop_o,
	output logic                       rx_flush_o,
	input  usart_frame_pkg::rx_entry_t rx_head_i,
	input  logic                       rx_empty_i,
	input  logic                       rx_drop_i
);
	import usart_reg_pkg::*;
	import usart_frame_pkg::*;

	logic [7:0]            ucsrb;
	logic [7:0]            ucsrc;
	logic [3:0]            ubrr_tmp; // UBRRH staging
	baud_t                 ubrr;
	baud_t                 ubrr_wr;
	logic                  txc;
	logic                  dor;
	logic                  u2x;
	logic                  wr_udr;
	logic                  wr_ucsra;
	logic                  wr_ucsrb;
	logic                  wr_ucsrc;
	logic                  wr_ubrrh;
	logic                  wr_ubrrl;
	logic                  rxc;
	logic                  udre;
	char_size_e            cs;
	logic [3:0]            width;
	logic [MAX_DATA_W-1:0] tx_data;
	logic [7:0]            ucsra_rd;
	logic [7:0]            ucsrb_rd;

	assign wr_udr   = ramwe_i && (ram_addr_i == UDR_ADDR);
	assign wr_ucsra = ramwe_i && (ram_addr_i == UCSRA_ADDR);
	assign wr_ucsrb = ramwe_i && (ram_addr_i == UCSRB_ADDR);
	assign wr_ucsrc = ramwe_i && (ram_addr_i == UCSRC_ADDR);
	assign wr_ubrrh = ramwe_i && (ram_addr_i == UBRRH_ADDR);
	assign wr_ubrrl = ramwe_i && (ram_addr_i == UBRRL_ADDR);
	assign ubrr_wr  = {ubrr_tmp, dbus_i};

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ucsrb    <= '0;
			ucsrc    <= UCSRC_RST;
			ubrr_tmp <= '0;
			ubrr     <= '0;
			u2x      <= 1'b0;
		end else begin
			if (wr_ucsrb)
				ucsrb <= dbus_i & ~(8'd1 << RXB8); // RXB8 comes from the FIFO head
			if (wr_ucsrc)
				ucsrc <= dbus_i;
			if (wr_ucsra)
				u2x <= dbus_i[U2X];
			if (wr_ubrrh)
				ubrr_tmp <= dbus_i[3:0];
			if (wr_ubrrl)
				ubrr <= ubrr_wr; // High nibble committed together with low byte
		end
	end

	// TXC and DOR are sticky
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			txc <= 1'b0;
			dor <= 1'b0;
		end else begin
			if (tx_done_i)
				txc <= 1'b1;
			else if (wr_ucsra && dbus_i[TXC])
				txc <= 1'b0;
			if (rx_drop_i)
				dor <= 1'b1;
			else if (rx_pop_o || rx_flush_o)
				dor <= 1'b0;
		end
	end

	assign rxc         = !rx_empty_i;
	assign udre        = !tx_full_i;
	assign rxen_o      = ucsrb[RXEN];
	assign txen_o      = ucsrb[TXEN];
	assign baud_o      = wr_ubrrl ? ubrr_wr : ubrr; // Counter reloads with the new value
	assign baud_load_o = wr_ubrrl;
	assign tx_wr_o     = wr_udr && ucsrb[TXEN] && !tx_full_i;
	assign rx_pop_o    = ramre_i && (ram_addr_i == UDR_ADDR) && !rx_empty_i;
	assign rx_flush_o  = wr_ucsrb && ucsrb[RXEN] && !dbus_i[RXEN];

	assign cs                 = to_char_size({ucsrb[UCSZ2], ucsrc[UCSZ1], ucsrc[UCSZ0]});
	assign width              = char_bits(cs);
	assign frame.char_size    = cs;
	assign frame.parity_en    = ucsrc[UPM1];
	assign frame.parity_odd   = ucsrc[UPM0];
	assign frame.two_stop     = ucsrc[USBS];
	assign frame.double_speed = u2x;

	// Data masked to width, parity above it, ones beyond
	assign tx_data = {ucsrb[TXB8], dbus_i} & ~({MAX_DATA_W{1'b1}} << width);

	always_comb begin
		tx_frame_o = {1'b1, tx_data} | ({TX_FRAME_W{1'b1}} << width);
		if (ucsrc[UPM1])
			tx_frame_o[width] = ^tx_data ^ ucsrc[UPM0];
	end

	always_comb begin
		ucsra_rd       = '0;
		ucsra_rd[RXC]  = rxc;
		ucsra_rd[TXC]  = txc;
		ucsra_rd[UDRE] = udre;
		ucsra_rd[FE]   = rxc && rx_head_i.fe;
		ucsra_rd[DOR]  = dor;
		ucsra_rd[UPE]  = rxc && rx_head_i.pe;
		ucsra_rd[U2X]  = u2x;
		ucsrb_rd       = ucsrb;
		ucsrb_rd[RXB8] = rx_head_i.data[8];
		out_en_o       = ramre_i;
		case (ram_addr_i)
			UDR_ADDR:   dbus_o = rx_head_i.data[7:0];
			UCSRA_ADDR: dbus_o = ucsra_rd;
			UCSRB_ADDR: dbus_o = ucsrb_rd;
			UCSRC_ADDR: dbus_o = ucsrc;
			UBRRH_ADDR: dbus_o = {4'h0, ubrr[11:8]};
			UBRRL_ADDR: dbus_o = ubrr[7:0];
			default: begin
				dbus_o   = '0;
				out_en_o = 1'b0; // Not ours
			end
		endcase
	end

	assign rxc_irq_o  = ucsrb[RXCIE] && rxc;
	assign txc_irq_o  = ucsrb[TXCIE] && txc;
	assign udre_irq_o = ucsrb[UDRIE] && udre;

endmodule

//--- hdl/usart_baud.sv
`timescale 1ns/1ns

module usart_baud (
	input  logic                 cp2,
	input  logic                 ireset,
	input  usart_reg_pkg::baud_t baud_i,
	input  logic                 load_i,
	input  logic                 enable_i,
	output logic                 tick_o
);
	import usart_reg_pkg::*;

	baud_t cnt;

	// One tick every baud_i+1 cycles
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			cnt    <= '0;
			tick_o <= 1'b0;
		end else if (load_i || !enable_i) begin
			cnt    <= baud_i; // Restart from the top
			tick_o <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= baud_i;
			tick_o <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			tick_o <= 1'b0;
		end
	end

endmodule

//--- hdl/usart_fifo.sv
`timescale 1ns/1ns

module usart_fifo #(
	parameter int  DEPTH   = 2,
	parameter type entry_t = logic [7:0]
) (
	input  logic   cp2,
	input  logic   ireset,
	input  logic   wr_i,
	input  entry_t din_i,
	input  logic   rd_i,
	input  logic   flush_i,
	output entry_t dout_o,
	output logic   full_o,
	output logic   empty_o
);
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	entry_t        mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] level;
	logic          push;
	logic          pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full_o  = (level == CW'(DEPTH));
	assign empty_o = (level == '0);
	assign push    = wr_i && !full_o; // Writes to a full FIFO are lost
	assign pop     = rd_i && !empty_o;
	assign dout_o  = mem[rd_ptr];

	always_ff @(posedge cp2) begin
		if (push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else if (flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			level <= level + CW'(push) - CW'(pop);
		end
	end

endmodule

//--- hdl/usart_tx.sv
`timescale 1ns/1ns

module usart_tx (
	input  logic                       cp2,
	input  logic                       ireset,
	usart_frame_if.tx_mp               frame,
	input  logic                       tick_i,
	input  logic                       txen_i,
	input  logic                       fifo_empty_i,
	input  usart_frame_pkg::tx_frame_t fifo_head_i,
	output logic                       pop_o,
	output logic                       done_o,
	output logic                       txd_o
);
	import usart_frame_pkg::*;

	typedef enum logic {TX_IDLE, TX_SEND} tx_state_e;

	tx_state_e           state;
	logic [TX_FRAME_W:0] sh;       // Start bit in the LSB
	logic [3:0]          tick_cnt;
	logic [3:0]          bit_cnt;  // Bits still to go
	logic [3:0]          n_bits;
	logic [3:0]          last;

	// Start, data, parity and one or two stop bits
	assign n_bits = 4'd2 + char_bits(frame.char_size) + 4'(frame.parity_en)
			+ 4'(frame.two_stop);
	assign last   = frame.double_speed ? 4'(OVERSAMPLE_U2X - 1) : 4'(OVERSAMPLE - 1);
	assign pop_o  = (state == TX_IDLE) && txen_i && !fifo_empty_i && tick_i;
	assign txd_o  = sh[0]; // All ones while idle

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state    <= TX_IDLE;
			sh       <= '1;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (pop_o) begin
						sh       <= {fifo_head_i, 1'b0};
						bit_cnt  <= n_bits;
						tick_cnt <= '0;
						state    <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (tick_i && tick_cnt == last) begin
						tick_cnt <= '0;
						sh       <= {1'b1, sh[TX_FRAME_W:1]}; // LSB first, ones shift in
						bit_cnt  <= bit_cnt - 1'b1;
						if (bit_cnt == 4'd1) begin
							state  <= TX_IDLE;
							done_o <= 1'b1;
						end
					end else if (tick_i) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/usart_rx.sv
`timescale 1ns/1ns

module usart_rx (
	input  logic                       cp2,
	input  logic                       ireset,
	usart_frame_if.rx_mp               frame,
	input  logic                       tick_i,
	input  logic                       rxen_i,
	input  logic                       rxd_i,
	input  logic                       fifo_full_i,
	output logic                       wr_o,
	output usart_frame_pkg::rx_entry_t entry_o,
	output logic                       drop_o
);
	import usart_frame_pkg::*;

	localparam int SH_W = MAX_DATA_W + 2; // Data, parity and stop

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA} rx_state_e;

	rx_state_e             state;
	logic [1:0]            sync;
	logic                  rxd_s;
	logic                  line_q;   // Line at the previous tick
	logic [1:0]            vote;     // First two of the three samples
	logic                  maj;
	logic [3:0]            tick_cnt;
	logic [3:0]            mid;
	logic [3:0]            last;
	logic                  at_decide;
	logic [3:0]            width;
	logic [3:0]            n_bits;
	logic [3:0]            bit_cnt;
	logic [SH_W-1:0]       sh;
	logic [SH_W-1:0]       full;
	logic [SH_W-1:0]       al;
	logic [MAX_DATA_W-1:0] rx_data;
	logic                  par_err;
	logic                  frm_err;

	assign rxd_s     = sync[1];
	assign mid       = frame.double_speed ? 4'(OVERSAMPLE_U2X / 2) : 4'(OVERSAMPLE / 2);
	assign last      = frame.double_speed ? 4'(OVERSAMPLE_U2X - 1) : 4'(OVERSAMPLE - 1);
	assign at_decide = (tick_cnt == mid + 4'd1);
	assign maj       = (vote[1] & vote[0]) | (vote[1] & rxd_s) | (vote[0] & rxd_s);
	assign width     = char_bits(frame.char_size);
	assign n_bits    = 4'd1 + width + 4'(frame.parity_en);

	// Deframe with the bit being taken now
	always_comb begin
		full    = {maj, sh[SH_W-1:1]};
		al      = full >> (4'(SH_W) - n_bits);
		rx_data = al[MAX_DATA_W-1:0] & ~({MAX_DATA_W{1'b1}} << width);
		par_err = frame.parity_en && (al[width] != (^rx_data ^ frame.parity_odd));
		frm_err = !al[width + 4'(frame.parity_en)];
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			sync   <= 2'b11;
			line_q <= 1'b1;
		end else begin
			sync <= {sync[0], rxd_i};
			if (tick_i)
				line_q <= rxd_s;
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			vote     <= '0;
			wr_o     <= 1'b0;
			drop_o   <= 1'b0;
		end else begin
			wr_o   <= 1'b0;
			drop_o <= 1'b0;
			if (!rxen_i) begin
				state <= RX_IDLE;
			end else if (tick_i) begin
				tick_cnt <= (tick_cnt == last) ? '0 : tick_cnt + 1'b1;
				if (tick_cnt == mid - 4'd1 || tick_cnt == mid)
					vote <= {vote[0], rxd_s};
				case (state)
					RX_IDLE: begin
						if (line_q && !rxd_s) begin // Falling edge is tick 0
							state    <= RX_START;
							tick_cnt <= 4'd1;
						end
					end
					RX_START: begin
						if (at_decide) begin
							state   <= maj ? RX_IDLE : RX_DATA; // Glitch goes back to idle
							bit_cnt <= '0;
						end
					end
					RX_DATA: begin
						if (at_decide) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == n_bits - 4'd1) begin // Stop bit
								state  <= RX_IDLE;
								wr_o   <= !fifo_full_i;
								drop_o <= fifo_full_i;
							end
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge cp2) begin
		if (tick_i && state == RX_DATA && at_decide) begin
			sh      <= full;
			entry_o <= '{fe: frm_err, pe: par_err, data: rx_data};
		end
	end

endmodule

//--- hdl/usart_top.sv
`timescale 1ns/1ns

module usart_top #(
	parameter usart_reg_pkg::reg_addr_t UDR_ADDR   = usart_reg_pkg::UDR_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRA_ADDR = usart_reg_pkg::UCSRA_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRB_ADDR = usart_reg_pkg::UCSRB_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UCSRC_ADDR = usart_reg_pkg::UCSRC_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UBRRH_ADDR = usart_reg_pkg::UBRRH_ADDR_DEF,
	parameter usart_reg_pkg::reg_addr_t UBRRL_ADDR = usart_reg_pkg::UBRRL_ADDR_DEF,
	parameter int                       RX_DEPTH   = 2,
	parameter int                       TX_DEPTH   = 1
) (
	input  logic                     cp2,
	input  logic                     ireset,
	input  usart_reg_pkg::reg_addr_t ram_addr_i,
	input  logic                     ramre_i,
	input  logic                     ramwe_i,
	input  logic [7:0]               dbus_i,
	output logic [7:0]               dbus_o,
	output logic                     out_en_o,
	input  logic                     rxd_i,
	output logic                     txd_o,
	output logic                     rxc_irq_o,
	output logic                     txc_irq_o,
	output logic                     udre_irq_o
);
	import usart_reg_pkg::*;
	import usart_frame_pkg::*;

	baud_t     baud;
	logic      baud_load;
	logic      rxen;
	logic      txen;
	logic      tick;
	tx_frame_t tx_frame;
	tx_frame_t tx_head;
	logic      tx_wr;
	logic      tx_pop;
	logic      tx_full;
	logic      tx_empty;
	logic      tx_done;
	rx_entry_t rx_entry;
	rx_entry_t rx_head;
	logic      rx_wr;
	logic      rx_pop;
	logic      rx_flush;
	logic      rx_full;
	logic      rx_empty;
	logic      rx_drop;

	usart_frame_if u_frame_if ();

	usart_ctrl #(
		.UDR_ADDR   (UDR_ADDR),
		.UCSRA_ADDR (UCSRA_ADDR),
		.UCSRB_ADDR (UCSRB_ADDR),
		.UCSRC_ADDR (UCSRC_ADDR),
		.UBRRH_ADDR (UBRRH_ADDR),
		.UBRRL_ADDR (UBRRL_ADDR)
	) u_ctrl (
		.cp2         (cp2),
		.ireset      (ireset),
		.ram_addr_i  (ram_addr_i),
		.ramre_i     (ramre_i),
		.ramwe_i     (ramwe_i),
		.dbus_i      (dbus_i),
		.dbus_o      (dbus_o),
		.out_en_o    (out_en_o),
		.rxc_irq_o   (rxc_irq_o),
		.txc_irq_o   (txc_irq_o),
		.udre_irq_o  (udre_irq_o),
		.frame       (u_frame_if),
		.baud_o      (baud),
		.baud_load_o (baud_load),
		.rxen_o      (rxen),
		.txen_o      (txen),
		.tx_wr_o     (tx_wr),
		.tx_frame_o  (tx_frame),
		.tx_full_i   (tx_full),
		.tx_done_i   (tx_done),
		.rx_pop_o    (rx_pop),
		.rx_flush_o  (rx_flush),
		.rx_head_i   (rx_head),
		.rx_empty_i  (rx_empty),
		.rx_drop_i   (rx_drop)
	);

	// Shared by both directions
	usart_baud u_baud (
		.cp2      (cp2),
		.ireset   (ireset),
		.baud_i   (baud),
		.load_i   (baud_load),
		.enable_i (rxen | txen),
		.tick_o   (tick)
	);

	usart_fifo #(
		.DEPTH   (TX_DEPTH),
		.entry_t (tx_frame_t)
	) u_tx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.wr_i    (tx_wr),
		.din_i   (tx_frame),
		.rd_i    (tx_pop),
		.flush_i (1'b0),
		.dout_o  (tx_head),
		.full_o  (tx_full),
		.empty_o (tx_empty)
	);

	usart_fifo #(
		.DEPTH   (RX_DEPTH),
		.entry_t (rx_entry_t)
	) u_rx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.wr_i    (rx_wr),
		.din_i   (rx_entry),
		.rd_i    (rx_pop),
		.flush_i (rx_flush),
		.dout_o  (rx_head),
		.full_o  (rx_full),
		.empty_o (rx_empty)
	);

	usart_tx u_tx (
		.cp2          (cp2),
		.ireset       (ireset),
		.frame        (u_frame_if),
		.tick_i       (tick),
		.txen_i       (txen),
		.fifo_empty_i (tx_empty),
		.fifo_head_i  (tx_head),
		.pop_o        (tx_pop),
		.done_o       (tx_done),
		.txd_o        (txd_o)
	);

	usart_rx u_rx (
		.cp2         (cp2),
		.ireset      (ireset),
		.frame       (u_frame_if),
		.tick_i      (tick),
		.rxen_i      (rxen),
		.rxd_i       (rxd_i),
		.fifo_full_i (rx_full),
		.wr_o        (rx_wr),
		.entry_o     (rx_entry),
		.drop_o      (rx_drop)
	);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic cp2_o,
	output logic ireset_o
);
	initial begin
		cp2_o    = 1'b0;
		ireset_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge cp2_o);
		ireset_o <= 1'b1; // Released on a rising edge
	end

	always #(PERIOD / 2) cp2_o = ~cp2_o;

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
	input logic        cp2_i,
	input logic [11:0] ram_addr_i,
	input logic        ramre_i,
	input logic [7:0]  dbus_i,
	input logic        out_en_i,
	input logic        txd_i,
	input logic [2:0]  irq_i // rxc, txc, udre
);
	int          mismatches = 0;
	int          failures   = 0;
	int          frames_seen = 0;
	logic [27:0] exp_q [$];  // Address, value, mask
	logic [12:0] line_bits [$];
	int          line_len [$];
	int          line_per [$];
	logic [27:0] e;
	logic [12:0] b;
	int          n;
	int          per;

	function automatic int frame_len(input logic [7:0] fmt);
		return 2 + fmt[3:0] + fmt[4] + fmt[6];
	endfunction

	// Format byte holds width in [3:0], parity enable, odd, two stop and U2X
	function automatic logic [12:0] ref_bits(input logic [8:0] d, input logic [7:0] fmt,
			input logic bad_par, input logic bad_stop);
		logic [12:0] s;
		logic        p;
		int          w;
		s    = '1;
		w    = fmt[3:0];
		p    = fmt[5] ^ bad_par;
		s[0] = 1'b0; // Start bit
		for (int i = 0; i < w; i++) begin
			s[1 + i] = d[i];
			p        = p ^ d[i];
		end
		if (fmt[4]) begin
			s[1 + w] = p;
			w++;
		end
		s[1 + w] = !bad_stop;
		return s;
	endfunction

	// Returns RXB8, FE, UPE and UDR
	function automatic logic [10:0] ref_rx(input logic [8:0] d, input logic [7:0] fmt,
			input logic bad_par, input logic bad_stop);
		logic [8:0] m;
		m = '0;
		for (int i = 0; i < fmt[3:0]; i++)
			m[i] = d[i];
		return {m[8], bad_stop, fmt[4] && bad_par, m[7:0]};
	endfunction

	task automatic expect_read(input logic [11:0] addr, input logic [7:0] v, input logic [7:0] m);
		exp_q.push_back({addr, v, m});
	endtask

	task automatic expect_frame(input logic [8:0] d, input logic [7:0] fmt, input int ubrr);
		line_bits.push_back(ref_bits(d, fmt, 1'b0, 1'b0));
		line_len.push_back(frame_len(fmt));
		line_per.push_back((fmt[7] ? 8 : 16) * (ubrr + 1));
	endtask

	// Status, control and data reads of one received frame
	task automatic expect_rx(input logic [8:0] d, input logic [7:0] fmt,
			input logic bad_par, input logic bad_stop);
		logic [10:0] r;
		r = ref_rx(d, fmt, bad_par, bad_stop);
		expect_read(12'h0C0, {1'b1, 2'b00, r[9], 1'b0, r[8], fmt[7], 1'b0}, 8'h9E);
		expect_read(12'h0C1, {6'b0, r[10], 1'b0}, 8'h02);
		expect_read(12'h0C6, r[7:0], 8'hFF);
	endtask

	task automatic expect_irq(input logic [2:0] x);
		@(negedge cp2_i);
		if (irq_i !== x) begin
			mismatches++;
			$display("Mismatch at %0t: irq %b, expected %b", $time, irq_i, x);
		end
	endtask

	task automatic expect_line_high();
		@(negedge cp2_i);
		if (txd_i !== 1'b1) begin
			mismatches++;
			$display("Mismatch at %0t: txd_o %b while idle", $time, txd_i);
		end
	endtask

	task automatic finish_checks();
		if (exp_q.size() != 0 || line_bits.size() != 0) begin
			failures++;
			$display("Expected reads or frames were left over at the end of the run");
		end
	endtask

	always @(negedge cp2_i) begin
		if (ramre_i) begin
			if (exp_q.size() == 0) begin
				failures++;
				$display("A bus read happened with no expected value at %0t", $time);
			end else begin
				e = exp_q.pop_front();
				if (ram_addr_i !== e[27:16] || out_en_i !== 1'b1 ||
						((dbus_i ^ e[15:8]) & e[7:0]) !== 8'h00) begin
					mismatches++;
					$display("Mismatch at %0t: read %h returned %h, expected %h mask %h",
						$time, ram_addr_i, dbus_i, e[15:8], e[7:0]);
				end
			end
		end
	end

	// Decode txd_o in the middle of each bit
	initial begin
		forever begin
			@(negedge txd_i);
			if (line_bits.size() == 0) begin
				failures++;
				$display("A frame started on txd_o with none expected at %0t", $time);
			end else begin
				b   = line_bits.pop_front();
				n   = line_len.pop_front();
				per = line_per.pop_front();
				repeat (per / 2) @(posedge cp2_i);
				for (int i = 0; i < n; i++) begin
					if (i > 0)
						repeat (per) @(posedge cp2_i);
					if (txd_i !== b[i]) begin
						mismatches++;
						$display("Mismatch at %0t: txd_o bit %0d is %b", $time, i, txd_i);
					end
				end
				frames_seen++;
			end
		end
	end

endmodule

//--- bench/tb_usart.sv
`timescale 1ns/1ns

module tb_usart;
	import usart_reg_pkg::*;

	localparam int UBRR     = 3;
	localparam int N_FRAMES = 18;
	localparam int LIMIT    = N_FRAMES * 12 * 16 * (UBRR + 1) + 2000;

	logic        cp2;
	logic        ireset;
	reg_addr_t   ram_addr_i;
	logic        ramre_i;
	logic        ramwe_i;
	logic [7:0]  dbus_i;
	logic [7:0]  dbus_o;
	logic        out_en_o;
	logic        txd_o;
	logic        rxc_irq_o;
	logic        txc_irq_o;
	logic        udre_irq_o;
	logic        force_line; // Drive rxd_i from the bench instead of txd_o
	logic        forced_rxd;
	logic [31:0] lfsr = 32'had8c;
	int          cycles = 0;
	logic [8:0]  d;
	logic [8:0]  r;
	logic [7:0]  fmt;
	logic [8:0]  sent [3];

	tb_clock u_clk (.cp2_o(cp2), .ireset_o(ireset));

	usart_top u_dut (
		.cp2        (cp2),
		.ireset     (ireset),
		.ram_addr_i (ram_addr_i),
		.ramre_i    (ramre_i),
		.ramwe_i    (ramwe_i),
		.dbus_i     (dbus_i),
		.dbus_o     (dbus_o),
		.out_en_o   (out_en_o),
		.rxd_i      (force_line ? forced_rxd : txd_o),
		.txd_o      (txd_o),
		.rxc_irq_o  (rxc_irq_o),
		.txc_irq_o  (txc_irq_o),
		.udre_irq_o (udre_irq_o)
	);

	tb_checker u_chk (
		.cp2_i      (cp2),
		.ram_addr_i (ram_addr_i),
		.ramre_i    (ramre_i),
		.dbus_i     (dbus_o),
		.out_en_i   (out_en_o),
		.txd_i      (txd_o),
		.irq_i      ({rxc_irq_o, txc_irq_o, udre_irq_o})
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	task automatic take_bits(input int n, output logic [8:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic bus_write(input reg_addr_t a, input logic [7:0] v);
		@(posedge cp2);
		ram_addr_i <= a;
		dbus_i     <= v;
		ramwe_i    <= 1'b1;
		@(posedge cp2);
		ramwe_i    <= 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t a);
		@(posedge cp2);
		ram_addr_i <= a;
		ramre_i    <= 1'b1;
		@(posedge cp2);
		ramre_i    <= 1'b0;
	endtask

	task automatic set_format(input logic [7:0] f, input logic txb8, input logic [7:0] ctl);
		logic [2:0] ucsz;
		ucsz = (f[3:0] == 4'd9) ? 3'b111 : 3'(f[3:0] - 4'd5);
		bus_write(UCSRC_ADDR_DEF, {2'b00, f[4], f[5], f[6], ucsz[1:0], 1'b0});
		bus_write(UCSRB_ADDR_DEF, ctl | {5'b0, ucsz[2], 1'b0, txb8});
		bus_write(UCSRA_ADDR_DEF, {6'b0, f[7], 1'b0});
	endtask

	task automatic read_rx();
		bus_read(UCSRA_ADDR_DEF);
		bus_read(UCSRB_ADDR_DEF);
		bus_read(UDR_ADDR_DEF);
	endtask

	// Loopback one frame and read it back
	task automatic loop_frame(input logic [8:0] v, input logic [7:0] f);
		set_format(f, v[8], 8'h98);
		u_chk.expect_frame(v, f, UBRR);
		bus_write(UDR_ADDR_DEF, v[7:0]);
		wait (rxc_irq_o);
		u_chk.expect_rx(v, f, 1'b0, 1'b0);
		read_rx();
	endtask

	task automatic force_frame(input logic [8:0] v, input logic [7:0] f,
			input logic bad_par, input logic bad_stop);
		logic [12:0] bits;
		set_format(f, v[8], 8'h98);
		bits = u_chk.ref_bits(v, f, bad_par, bad_stop);
		for (int i = 0; i < u_chk.frame_len(f); i++) begin
			@(posedge cp2);
			forced_rxd <= bits[i];
			repeat (16 * (UBRR + 1) - 1) @(posedge cp2);
		end
		@(posedge cp2);
		forced_rxd <= 1'b1;
		wait (rxc_irq_o);
		u_chk.expect_rx(v, f, bad_par, bad_stop);
		read_rx();
	endtask

	always @(posedge cp2) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		ram_addr_i = '0;
		ramre_i    = 1'b0;
		ramwe_i    = 1'b0;
		dbus_i     = '0;
		force_line = 1'b0;
		forced_rxd = 1'b1;
		wait (ireset);
		// Reset values
		u_chk.expect_read(UCSRA_ADDR_DEF, 8'h20, 8'hFF);
		u_chk.expect_read(UCSRC_ADDR_DEF, 8'h06, 8'hFF);
		u_chk.expect_read(UBRRH_ADDR_DEF, 8'h00, 8'hFF);
		u_chk.expect_read(UBRRL_ADDR_DEF, 8'h00, 8'hFF);
		bus_read(UCSRA_ADDR_DEF);
		bus_read(UCSRC_ADDR_DEF);
		bus_read(UBRRH_ADDR_DEF);
		bus_read(UBRRL_ADDR_DEF);
		u_chk.expect_line_high();
		u_chk.expect_irq(3'b000);
		bus_write(UBRRH_ADDR_DEF, 8'h00);
		bus_write(UBRRL_ADDR_DEF, 8'(UBRR));
		for (int i = 0; i < 4; i++) begin // 8N1
			take_bits(8, d);
			loop_frame(d, 8'h08);
		end
		for (int i = 0; i < 8; i++) begin
			take_bits(2, r);
			fmt[3:0] = (r[1:0] == 2'd3) ? 4'd9 : 4'd5 + r[1:0];
			take_bits(4, r);
			fmt[7:4] = r[3:0];
			take_bits(9, d);
			loop_frame(d, fmt);
		end
		force_line <= 1'b1;
		take_bits(8, d);
		force_frame(d, 8'h18, 1'b1, 1'b0); // 8E1 with the parity bit flipped
		take_bits(8, d);
		force_frame(d, 8'h18, 1'b0, 1'b1);
		force_line <= 1'b0;
		// Overrun with three frames and no reads
		set_format(8'h08, 1'b0, 8'hB8);
		for (int i = 0; i < 3; i++) begin
			take_bits(8, sent[i]);
			@(negedge cp2);
			while (!udre_irq_o)
				@(negedge cp2);
			u_chk.expect_frame(sent[i], 8'h08, UBRR);
			bus_write(UDR_ADDR_DEF, sent[i][7:0]);
			if (i == 1)
				u_chk.expect_irq(3'b000); // Buffer full behind the first frame
		end
		while (u_chk.frames_seen < 15)
			@(posedge cp2);
		repeat (32 * (UBRR + 1)) @(posedge cp2);
		u_chk.expect_read(UCSRA_ADDR_DEF, 8'h88, 8'h88);
		u_chk.expect_read(UDR_ADDR_DEF, sent[0][7:0], 8'hFF);
		u_chk.expect_read(UCSRA_ADDR_DEF, 8'h80, 8'h88);
		u_chk.expect_read(UDR_ADDR_DEF, sent[1][7:0], 8'hFF);
		u_chk.expect_read(UCSRA_ADDR_DEF, 8'h00, 8'h80);
		for (int i = 0; i < 2; i++) begin
			bus_read(UCSRA_ADDR_DEF);
			bus_read(UDR_ADDR_DEF);
		end
		bus_read(UCSRA_ADDR_DEF);
		// Interrupt levels
		bus_write(UCSRB_ADDR_DEF, 8'hD8);
		bus_write(UCSRA_ADDR_DEF, 8'h40);
		u_chk.expect_irq(3'b000);
		take_bits(8, d);
		u_chk.expect_frame(d, 8'h08, UBRR);
		bus_write(UDR_ADDR_DEF, d[7:0]);
		wait (rxc_irq_o);
		repeat (16 * (UBRR + 1)) @(posedge cp2); // Past the end of the stop bit
		u_chk.expect_irq(3'b110);
		u_chk.expect_read(UDR_ADDR_DEF, d[7:0], 8'hFF);
		bus_read(UDR_ADDR_DEF);
		u_chk.expect_irq(3'b010);
		bus_write(UCSRA_ADDR_DEF, 8'h40);
		u_chk.expect_irq(3'b000);
		bus_write(UCSRB_ADDR_DEF, 8'hB8);
		u_chk.expect_irq(3'b001);
		repeat (4) @(posedge cp2);
		u_chk.finish_checks();
		$display("Closing count: %0d mismatches, %0d other failures",
			u_chk.mismatches, u_chk.failures);
		if (u_chk.mismatches + u_chk.failures == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- files.f
hdl/usart_reg_pkg.sv
hdl/usart_frame_pkg.sv
hdl/usart_frame_if.sv
hdl/usart_ctrl.sv
hdl/usart_baud.sv
hdl/usart_fifo.sv
hdl/usart_tx.sv
hdl/usart_rx.sv
hdl/usart_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_usart.sv

//--- Bender.yml
package:
  name: usart

sources:
  - hdl/usart_reg_pkg.sv
  - hdl/usart_frame_pkg.sv
  - hdl/usart_frame_if.sv
  - hdl/usart_ctrl.sv
  - hdl/usart_baud.sv
  - hdl/usart_fifo.sv
  - hdl/usart_tx.sv
  - hdl/usart_rx.sv
  - hdl/usart_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_usart.sv
